// ==== project.f ====
+incdir+include
logic/bp_pkg.sv
logic/bp_table_ram.sv
logic/fetch_pc_stage.sv
logic/bp_lookup_stage.sv
logic/bp_update_stage.sv
logic/branch_predict_top.sv
bench/bp_checker.sv
bench/bp_tb.sv

// ==== bench/bp_tb.sv ====
/*
 * testbench top for the branch prediction unit
 * clock, reset, memory responder, execute model, test sequence, timeout
 */

`timescale 1ns/10ps

`include "bp_params.svh"

module bp_tb;
    import bp_pkg::*;

    localparam int TOTAL_FETCHES = 175;
    localparam int RESET_CYCLES  = 16;
    localparam int CYCLE_LIMIT   = TOTAL_FETCHES * 12 + RESET_CYCLES;
    localparam int SLOTS         = 2;

    logic           clk = 1'b0;
    logic           rst;
    logic           fetch_req;
    logic [31:0]    fetch_addr;
    logic           fetch_ack;
    fetch_tag_t     fetch_tag;
    branch_result_t br_result;

    int ack_wait;
    int done_count = 0;
    int cycles = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int bench_fails = 0;
    int err_mark;
    int redir_mark;

    // execute program map, one branch per slot
    logic        map_used [SLOTS];
    logic [31:0] map_pc [SLOTS];
    logic        map_taken [SLOTS];
    logic [31:0] map_target [SLOTS];
    fetch_tag_t  slot_tag [SLOTS];   // last tag seen at each mapped pc

    always #5 clk = ~clk;

    branch_predict_top DUT (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_tag  (fetch_tag),
        .br_result  (br_result)
    );

    bp_checker CHK (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_tag  (fetch_tag),
        .br_result  (br_result)
    );

    // ======================================================================
    // memory responder and execute model
    // ======================================================================
    always @(posedge clk) begin
        if (rst) begin
            fetch_ack <= 1'b0;
            ack_wait  <= $urandom_range(3);
        end else if (fetch_req && !fetch_ack) begin
            if (ack_wait == 0) fetch_ack <= 1'b1;
            else               ack_wait  <= ack_wait - 1;
        end else if (!fetch_req && fetch_ack) begin
            fetch_ack <= 1'b0;
            ack_wait  <= $urandom_range(3);   // delay for the next fetch
        end
    end

    always @(posedge clk) begin
        br_result <= '0;                      // single-cycle strobe
        if (!rst && fetch_req && fetch_ack) begin
            done_count <= done_count + 1;
            for (int s = 0; s < SLOTS; s++) begin
                if (map_used[s] && map_pc[s] == fetch_addr) begin
                    slot_tag[s]         <= fetch_tag;
                    br_result.valid     <= 1'b1;
                    br_result.pc        <= fetch_tag.pc;
                    br_result.taken     <= map_taken[s];
                    br_result.jump_pc   <= map_target[s];
                    br_result.pred_used <= fetch_tag.pred_used;
                    br_result.pred_pc   <= fetch_tag.pred_pc;
                    br_result.hit_way   <= fetch_tag.hit_way;
                    br_result.counter   <= fetch_tag.counter;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run hung waiting for fetch_ack after %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic set_branch(input int s, input logic [31:0] pc, input logic taken,
                              input logic [31:0] target);
        map_used[s]   <= 1'b1;
        map_pc[s]     <= pc;
        map_taken[s]  <= taken;
        map_target[s] <= target;
        slot_tag[s]   <= '0;
    endtask

    task automatic clear_map();
        for (int s = 0; s < SLOTS; s++) begin
            map_used[s] <= 1'b0;
            slot_tag[s] <= '0;
        end
    endtask

    task automatic run_fetches(input int n);
        int target;
        target = done_count + n;
        while (done_count < target) @(posedge clk);
    endtask

    task automatic bench_error(input string msg);
        $display("%0t: %s", $time, msg);
        bench_fails++;
    endtask

    task automatic start_test();
        err_mark   = CHK.errors + bench_fails;
        redir_mark = CHK.redirects;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (CHK.errors + bench_fails > err_mark) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        void'($urandom(87564));
        rst       = 1'b1;
        fetch_ack = 1'b0;
        br_result = '0;
        clear_map();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        start_test();
        run_fetches(8);                       // 0x00 to 0x1c
        finish_test("1 sequential fetch");

        start_test();
        set_branch(0, 32'h30, 1'b1, 32'h10);  // loop back
        run_fetches(7);
        if (CHK.redirects - redir_mark != 1) bench_error("first taken branch gave no single redirect");
        finish_test("2 first taken branch");

        start_test();
        run_fetches(10);
        if (!slot_tag[0].pred_used || slot_tag[0].counter != 2'd3 || slot_tag[0].pred_pc != 32'h10)
            bench_error("trained branch was not predicted strongly taken");
        if (CHK.redirects != redir_mark) bench_error("trained branch still redirected");
        finish_test("3 trained prediction");

        start_test();
        set_branch(0, 32'h30, 1'b0, 32'h10);
        set_branch(1, 32'h48, 1'b1, 32'h10);
        run_fetches(60);
        if (!slot_tag[0].pred_used || slot_tag[0].counter > 2'd1 || slot_tag[0].pred_pc != 32'h34)
            bench_error("counter did not walk down to a fall-through target");
        if (CHK.redirects - redir_mark < 2) bench_error("not-taken outcomes gave too few redirects");
        finish_test("4 counter walk down");

        start_test();
        clear_map();
        set_branch(0, 32'h40, 1'b1, 32'h13c);  // same index, different tags
        set_branch(1, 32'h140, 1'b1, 32'h0c);
        run_fetches(90);
        if (!slot_tag[0].pred_used || !slot_tag[1].pred_used ||
            slot_tag[0].hit_way == slot_tag[1].hit_way ||
            slot_tag[0].pred_pc != 32'h13c || slot_tag[1].pred_pc != 32'h0c)
            bench_error("aliasing branches do not both predict from separate ways");
        finish_test("5 two ways");

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d, bench errors %0d",
                 tests_run, tests_failed, CHK.checks, CHK.errors, bench_fails);
        if (tests_failed == 0 && CHK.errors == 0 && bench_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/bp_checker.sv ====
/*
 * fetch stream checker
 * reference branch table, training function, expected fetch address
 * and fetch tag compare
 */

`timescale 1ns/10ps

`include "bp_params.svh"

module bp_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    input  logic [31:0]            fetch_addr,
    input  logic                   fetch_ack,
    input  bp_pkg::fetch_tag_t     fetch_tag,
    input  bp_pkg::branch_result_t br_result
);
    import bp_pkg::*;

    localparam int WAYS  = `BP_WAYS;
    localparam int SETS  = `BP_TABLE_ENTRIES;
    localparam int IDX_W = `BP_INDEX_W;
    localparam int TAG_W = `BP_TAG_W;

    logic             ref_valid [WAYS][SETS];
    logic [TAG_W-1:0] ref_tag [WAYS][SETS];
    logic [1:0]       ref_ctr [WAYS][SETS];
    logic [31:0]      ref_target [WAYS][SETS];

    int              errors = 0;
    int              checks = 0;
    int              redirects = 0;
    int              ring_idx;     // way the replacement ring points at this cycle
    logic [31:0]     exp_pc;
    logic            pend;
    logic [31:0]     pend_pc;
    logic            cur_use;      // expected prediction for the fetch in flight
    logic [31:0]     cur_target;
    logic [1:0]      cur_ctr;
    logic [WAYS-1:0] cur_ways;     // expected hit way vector
    logic            req_q;

    function automatic void lookup(input logic [31:0] pc, output logic use_it,
                                   output logic [31:0] target, output logic [1:0] ctr,
                                   output logic [WAYS-1:0] ways);
        int idx;
        idx    = pc[2 +: IDX_W];
        use_it = 1'b0;
        target = pc + 32'd4;
        ctr    = 2'd0;
        ways   = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == pc[31 -: TAG_W]) begin
                use_it  = (`BP_USE_PREDICTOR != 0);
                target  = ref_target[w][idx];
                ctr     = ref_ctr[w][idx];
                ways[w] = 1'b1;
            end
        end
    endfunction

    // ======================================================================
    // reference training rules
    // ======================================================================
    function automatic void train_ref(input branch_result_t br, input int ring,
                                      output logic [1:0] ctr, output logic [31:0] target,
                                      output int way, output logic redir,
                                      output logic [31:0] right_pc);
        logic [31:0] fall;
        fall = br.pc + 32'd4;
        if (!br.pred_used)   ctr = br.taken ? 2'd3 : 2'd0;
        else if (br.taken)   ctr = (br.counter == 2'd3) ? 2'd3 : br.counter + 2'd1;
        else                 ctr = (br.counter == 2'd0) ? 2'd0 : br.counter - 2'd1;
        target   = ctr[1] ? br.jump_pc : fall;
        way      = ring;
        if (br.pred_used) begin
            for (int w = 0; w < WAYS; w++) if (br.hit_way[w]) way = w;
        end
        right_pc = br.taken ? br.jump_pc : fall;
        redir    = br.pred_used ? (br.pred_pc != right_pc) : br.taken;
    endfunction

    always @(posedge clk) begin
        logic [1:0]  n_ctr;
        logic [31:0] n_target;
        logic [31:0] n_pc;
        logic        n_redir;
        int          n_way;
        int          n_idx;
        if (rst) begin
            foreach (ref_valid[w, s]) ref_valid[w][s] = 1'b0;
            ring_idx = 0;
            exp_pc   = 32'h0;
            pend     = 1'b0;
            cur_use  = 1'b0;
            cur_ways = '0;
            req_q    = 1'b0;
        end else begin
            ring_idx = (ring_idx + 1) % WAYS;
            if (fetch_req && !req_q) begin
                checks++;
                if (fetch_ack) begin
                    $display("%0t: request rose while ack was still high", $time);
                    errors++;
                end
                if (fetch_addr !== exp_pc) begin
                    $display("Mismatch at %0t: fetch_addr %h, expected %h",
                             $time, fetch_addr, exp_pc);
                    errors++;
                end
            end
            if (fetch_req && fetch_ack) begin
                checks++;
                if (fetch_tag.pc !== exp_pc || fetch_tag.hit_way !== cur_ways) begin
                    $display("Mismatch at %0t: tag pc %h way %b, expected %h %b",
                             $time, fetch_tag.pc, fetch_tag.hit_way, exp_pc, cur_ways);
                    errors++;
                end
                if (fetch_tag.pred_used !== cur_use ||
                    (cur_use && (fetch_tag.counter !== cur_ctr ||
                                 fetch_tag.pred_pc !== cur_target))) begin
                    $display("Mismatch at %0t: tag %h used %b ctr %0d pred %h, exp %b %0d %h",
                             $time, exp_pc, fetch_tag.pred_used, fetch_tag.counter,
                             fetch_tag.pred_pc, cur_use, cur_ctr, cur_target);
                    errors++;
                end
                // priority is redirect, then prediction, then sequential
                exp_pc = pend ? pend_pc : (cur_use ? cur_target : exp_pc + 32'd4);
                pend   = 1'b0;
                lookup(exp_pc, cur_use, cur_target, cur_ctr, cur_ways);
            end
            if (br_result.valid) begin
                train_ref(br_result, ring_idx, n_ctr, n_target, n_way, n_redir, n_pc);
                n_idx = br_result.pc[2 +: IDX_W];
                ref_valid[n_way][n_idx]  = 1'b1;
                ref_tag[n_way][n_idx]    = br_result.pc[31 -: TAG_W];
                ref_ctr[n_way][n_idx]    = n_ctr;
                ref_target[n_way][n_idx] = n_target;
                if (n_redir) begin
                    pend    = 1'b1;   // newest redirect wins
                    pend_pc = n_pc;
                    redirects++;
                end
            end
            req_q = fetch_req;
        end
    end

endmodule

// ==== logic/branch_predict_top.sv ====
/*
 * branch prediction unit top level
 * PC, lookup and update stages on the memory port and branch result input
 */

`timescale 1ns/10ps

module branch_predict_top (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   fetch_req,
    output logic [31:0]            fetch_addr,
    input  logic                   fetch_ack,
    output bp_pkg::fetch_tag_t     fetch_tag,
    input  bp_pkg::branch_result_t br_result
);
    import bp_pkg::*;

    logic         new_request;
    logic [31:0]  next_pc;
    prediction_t  prediction;
    table_write_t table_write;
    redirect_t    redirect;

    fetch_pc_stage u_pc_stage (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ack   (fetch_ack),
        .fetch_tag   (fetch_tag),
        .new_request (new_request),
        .next_pc     (next_pc),
        .prediction  (prediction),
        .redirect    (redirect)
    );

    // tags compared against the address currently on the memory port
    bp_lookup_stage u_lookup_stage (
        .clk         (clk),
        .rst         (rst),
        .new_request (new_request),
        .next_pc     (next_pc),
        .fetch_pc    (fetch_addr),
        .table_write (table_write),
        .prediction  (prediction)
    );

    bp_update_stage u_update_stage (
        .clk         (clk),
        .rst         (rst),
        .br_result   (br_result),
        .table_write (table_write),
        .redirect    (redirect)
    );

endmodule

// ==== logic/bp_update_stage.sv ====
/*
 * table training from resolved branches
 * counter update, stored target, replacement ring, redirect
 */

`timescale 1ns/10ps

`include "bp_params.svh"

module bp_update_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  bp_pkg::branch_result_t br_result,
    output bp_pkg::table_write_t   table_write,
    output bp_pkg::redirect_t      redirect
);
    import bp_pkg::*;

    localparam int WAYS  = `BP_WAYS;
    localparam int IDX_W = `BP_INDEX_W;
    localparam int TAG_W = `BP_TAG_W;

    branch_result_t  br_q;
    logic [WAYS-1:0] ring;        // one-hot replacement pointer
    logic [WAYS-1:0] write_way;
    logic [1:0]      new_ctr;
    logic [31:0]     seq_pc;
    logic [31:0]     correct_pc;
    logic [31:0]     stored_target;

    // ======================================================================
    // result register and replacement ring
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) br_q.valid <= 1'b0;
        else     br_q       <= br_result;
    end

    // rotates every cycle whether or not a write happens
    always_ff @(posedge clk) begin
        if (rst) ring <= WAYS'(1);
        else     ring <= (ring << 1) | WAYS'(ring[WAYS-1]);
    end

    // ======================================================================
    // training
    // ======================================================================
    always_comb begin
        if (!br_q.pred_used) begin
            new_ctr = br_q.taken ? 2'b11 : 2'b00;  // fresh entry starts strong
        end else if (br_q.taken) begin
            new_ctr = (br_q.counter == 2'b11) ? 2'b11 : br_q.counter + 2'd1;
        end else begin
            new_ctr = (br_q.counter == 2'b00) ? 2'b00 : br_q.counter - 2'd1;
        end
    end

    assign seq_pc        = br_q.pc + 32'd4;
    assign correct_pc    = br_q.taken ? br_q.jump_pc : seq_pc;
    assign stored_target = new_ctr[1] ? br_q.jump_pc : seq_pc;  // weak counters point past

    // keep the way that hit, otherwise replace
    assign write_way = br_q.pred_used ? br_q.hit_way : ring;

    always_comb begin
        table_write.we            = {WAYS{br_q.valid}} & write_way;
        table_write.index         = br_q.pc[2 +: IDX_W];
        table_write.entry.valid   = 1'b1;
        table_write.entry.tag     = br_q.pc[31 -: TAG_W];
        table_write.entry.counter = new_ctr;
        table_write.target        = stored_target;
    end

    // ======================================================================
    // redirect
    // ======================================================================
    always_comb begin
        redirect.pc = correct_pc;
        if (br_q.pred_used) begin
            redirect.valid = br_q.valid && (br_q.pred_pc != correct_pc);
        end else begin
            redirect.valid = br_q.valid && br_q.taken;  // fell through a taken branch
        end
    end

endmodule

// ==== logic/bp_lookup_stage.sv ====
/*
 * branch target table lookup
 * per-way tag and target banks, valid flops, tag compare, hit-way select
 */

`timescale 1ns/10ps

`include "bp_params.svh"

module bp_lookup_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 new_request,
    input  logic [31:0]          next_pc,
    input  logic [31:0]          fetch_pc,
    input  bp_pkg::table_write_t table_write,
    output bp_pkg::prediction_t  prediction
);
    import bp_pkg::*;

    localparam int WAYS      = `BP_WAYS;
    localparam int IDX_W     = `BP_INDEX_W;
    localparam int TAG_W     = `BP_TAG_W;
    localparam int WAY_IDX_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    bp_entry_t                    rd_entry [WAYS];
    logic [31:0]                  rd_target [WAYS];
    logic [`BP_TABLE_ENTRIES-1:0] valid_bits [WAYS];
    logic                         valid_rd [WAYS];
    logic [WAYS-1:0]              tag_hits;
    logic [WAY_IDX_W-1:0]         hit_idx;
    logic [IDX_W-1:0]             rd_index;

    assign rd_index = next_pc[2 +: IDX_W];

    // ======================================================================
    // per-way storage
    // ======================================================================
    for (genvar i = 0; i < WAYS; i++) begin : g_way
        bp_table_ram #(
            .DATA_W($bits(bp_entry_t))
        ) u_tag_bank (
            .clk        (clk),
            .write_en   (table_write.we[i]),
            .write_addr (table_write.index),
            .write_data (table_write.entry),
            .read_en    (new_request),
            .read_addr  (rd_index),
            .read_data  (rd_entry[i])
        );

        bp_table_ram #(
            .DATA_W(32)
        ) u_target_bank (
            .clk        (clk),
            .write_en   (table_write.we[i]),
            .write_addr (table_write.index),
            .write_data (table_write.target),
            .read_en    (new_request),
            .read_addr  (rd_index),
            .read_data  (rd_target[i])
        );

        // valid flops beside the RAM, all cleared together on reset
        always_ff @(posedge clk) begin
            if (rst) begin
                valid_bits[i] <= '0;
            end else if (table_write.we[i]) begin
                valid_bits[i][table_write.index] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst)              valid_rd[i] <= 1'b0;
            else if (new_request) valid_rd[i] <= valid_bits[i][rd_index];  // tracks the RAM read
        end

        // upper pc bits of the fetch being served
        assign tag_hits[i] = valid_rd[i] && rd_entry[i].valid
                             && (rd_entry[i].tag == fetch_pc[31 -: TAG_W]);
    end

    // one-hot hits to a way number
    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (tag_hits[w]) hit_idx = WAY_IDX_W'(w);
        end
    end

    always_comb begin
        prediction.hit      = |tag_hits;
        prediction.use_pred = (`BP_USE_PREDICTOR != 0) && prediction.hit;
        prediction.target   = rd_target[hit_idx];
        prediction.hit_way  = tag_hits;
        prediction.counter  = rd_entry[hit_idx].counter;
    end

endmodule

// ==== logic/fetch_pc_stage.sv ====
/*
 * fetch address register and four-phase memory requester
 * redirect latch and next address choice
 */

`timescale 1ns/10ps

module fetch_pc_stage (
    input  logic                clk,
    input  logic                rst,
    output logic                fetch_req,
    output logic [31:0]         fetch_addr,
    input  logic                fetch_ack,
    output bp_pkg::fetch_tag_t  fetch_tag,
    output logic                new_request,
    output logic [31:0]         next_pc,
    input  bp_pkg::prediction_t prediction,
    input  bp_pkg::redirect_t   redirect
);
    import bp_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [1:0] {
        ST_BOOT,  // first table read after reset
        ST_REQ,   // req high, waiting for ack
        ST_DROP,  // req low, waiting for ack to fall
        ST_GAP    // one idle cycle before the next req
    } state_t;

    state_t      state, state_next;
    logic [31:0] pc_q;
    logic [31:0] seq_pc;
    logic        redir_pending;
    logic [31:0] redir_pc;
    logic        fetch_done;

    assign seq_pc     = pc_q + 32'd4;
    assign fetch_done = (state == ST_REQ) && fetch_ack;

    // ======================================================================
    // requester FSM
    // ======================================================================
    always_comb begin
        state_next = state;
        case (state)
            ST_BOOT: state_next = ST_GAP;
            ST_REQ:  if (fetch_ack) state_next = ST_DROP;
            ST_DROP: if (!fetch_ack) state_next = ST_GAP;
            ST_GAP:  if (!fetch_ack) state_next = ST_REQ;
            default: state_next = ST_BOOT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= ST_BOOT;
        else     state <= state_next;
    end

    assign fetch_req  = (state == ST_REQ);
    assign fetch_addr = pc_q;

    // table read for the address about to be fetched
    assign new_request = fetch_done || (state == ST_BOOT);

    // ======================================================================
    // next address and redirect latch
    // ======================================================================
    always_comb begin
        if (state == ST_BOOT)        next_pc = pc_q;
        else if (redirect.valid)     next_pc = redirect.pc;  // arriving right at ack
        else if (redir_pending)      next_pc = redir_pc;
        else if (prediction.use_pred) next_pc = prediction.target;
        else                         next_pc = seq_pc;
    end

    always_ff @(posedge clk) begin
        if (rst)             pc_q <= RESET_PC;
        else if (fetch_done) pc_q <= next_pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            redir_pending <= 1'b0;
        end else if (fetch_done) begin
            redir_pending <= 1'b0;    // consumed by this ack
        end else if (redirect.valid) begin
            redir_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect.valid) redir_pc <= redirect.pc;  // newest wins
    end

    always_comb begin
        fetch_tag.pc        = pc_q;
        fetch_tag.pred_used = prediction.use_pred;
        fetch_tag.pred_pc   = prediction.use_pred ? prediction.target : seq_pc;
        fetch_tag.hit_way   = prediction.hit_way;
        fetch_tag.counter   = prediction.counter;
    end

endmodule

// ==== logic/bp_table_ram.sv ====
/*
 * simple dual-port table RAM
 * one write port, one registered read port that holds when idle
 */

`timescale 1ns/10ps

`include "bp_params.svh"

module bp_table_ram #(
    parameter int DATA_W = 32
) (
    input  logic                   clk,
    input  logic                   write_en,
    input  logic [`BP_INDEX_W-1:0] write_addr,
    input  logic [DATA_W-1:0]      write_data,
    input  logic                   read_en,
    input  logic [`BP_INDEX_W-1:0] read_addr,
    output logic [DATA_W-1:0]      read_data
);

    // contents are not cleared, the valid flops in the lookup stage cover that
    logic [DATA_W-1:0] mem [`BP_TABLE_ENTRIES];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // read data stays put until the next read
    always_ff @(posedge clk) begin
        if (read_en) begin
            read_data <= mem[read_addr];  // old data on a same-address write
        end
    end

endmodule

// ==== logic/bp_pkg.sv ====
/*
 * shared types of the branch prediction unit
 * table entry, fetch tag, branch result, table write, redirect, prediction
 */

`include "bp_params.svh"

package bp_pkg;

    // one tag bank word
    typedef struct packed {
        logic                 valid;
        logic [`BP_TAG_W-1:0] tag;
        logic [1:0]           counter;  // 2-bit saturating counter
    } bp_entry_t;

    // carried with each fetch toward execute
    typedef struct packed {
        logic [31:0]         pc;
        logic                pred_used;
        logic [31:0]         pred_pc;
        logic [`BP_WAYS-1:0] hit_way;   // one-hot
        logic [1:0]          counter;
    } fetch_tag_t;

    // resolved branch, echoes the fetch tag fields back
    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        logic                taken;
        logic [31:0]         jump_pc;
        logic                pred_used;
        logic [31:0]         pred_pc;
        logic [`BP_WAYS-1:0] hit_way;
        logic [1:0]          counter;
    } branch_result_t;

    typedef struct packed {
        logic [`BP_WAYS-1:0]   we;      // one enable per way
        logic [`BP_INDEX_W-1:0] index;
        bp_entry_t             entry;
        logic [31:0]           target;
    } table_write_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic                hit;
        logic                use_pred;  // hit qualified by the predictor enable
        logic [31:0]         target;
        logic [`BP_WAYS-1:0] hit_way;
        logic [1:0]          counter;
    } prediction_t;

endpackage

// ==== include/bp_params.svh ====
/*
 * branch predictor sizing and enable macros
 * table depth, way count, index and tag widths
 */

`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// ======================================================================
// table geometry
// ======================================================================
`define BP_TABLE_ENTRIES 64                        // sets per way
`define BP_WAYS 2                                  // associativity

// index comes from pc bits above bit 1
`define BP_INDEX_W $clog2(`BP_TABLE_ENTRIES)
`define BP_TAG_W (30 - `BP_INDEX_W)                // remaining upper pc bits

// 0 keeps training the table but never follows its targets
`define BP_USE_PREDICTOR 1

`endif
